//--- src/tlb_cfg_pkg.sv
/*
 * Sizing constants of the TLB request path.
 * TLB_IDX_BITS must hold TLB_ENTRIES, and PMTU_BYTES must fit in LEN_BITS.
 */
`default_nettype none

package tlb_cfg_pkg;

  ////////////////////
  // Address and field widths
  ////////////////////
  localparam int VADDR_BITS = 32;
  localparam int PADDR_BITS = 32;
  localparam int LEN_BITS = 16;
  localparam int PID_BITS = 6;

  // 4 KiB pages
  localparam int PAGE_BITS = 12;

  ////////////////////
  // Chunking and TLB sizing
  ////////////////////
  // Largest chunk sent downstream
  localparam int PMTU_BYTES = 256;

  localparam int TLB_ENTRIES = 8;
  localparam int TLB_IDX_BITS = 3;

endpackage

`default_nettype wire

//--- src/tlb_types_pkg.sv
/*
 * Vector types of the TLB request path, sized from the configuration package.
 * Page numbers drop the page offset bits of the matching address.
 */
`default_nettype none

package tlb_types_pkg;

  import tlb_cfg_pkg::*;

  ////////////////////
  // Addresses
  ////////////////////
  typedef logic [VADDR_BITS-1:0] vaddr_t;
  typedef logic [PADDR_BITS-1:0] paddr_t;

  // Page numbers
  typedef logic [VADDR_BITS-PAGE_BITS-1:0] vpn_t;
  typedef logic [PADDR_BITS-PAGE_BITS-1:0] ppn_t;

  ////////////////////
  // Request fields
  ////////////////////
  // Byte count of a request or chunk
  typedef logic [LEN_BITS-1:0] len_t;

  typedef logic [PID_BITS-1:0] pid_t;

  // Entry index for the TLB write port
  typedef logic [TLB_IDX_BITS-1:0] tlb_idx_t;

endpackage

`default_nettype wire

//--- src/tlb_intf.sv
/*
 * Stage-to-stage links of the TLB request path, valid/ready handshake.
 * Valid and data hold stable until the transfer edge.
 */
`timescale 1ns/1ps
`default_nettype none

// Parser to lookup, one chunk per transfer
interface chunk_if;

  import tlb_types_pkg::*;

  logic   valid;
  logic   ready;
  vaddr_t vaddr;
  len_t   len;
  logic   last;
  pid_t   pid;

  modport src (output valid, output vaddr, output len, output last, output pid, input ready);
  modport dst (input valid, input vaddr, input len, input last, input pid, output ready);

endinterface

// Lookup to result, chunk plus translation
interface xlat_if;

  import tlb_types_pkg::*;

  logic   valid;
  logic   ready;
  paddr_t paddr;
  vaddr_t vaddr;
  len_t   len;
  logic   last;
  pid_t   pid;
  // Zero paddr when low
  logic   hit;

  modport src (output valid, output paddr, output vaddr, output len, output last,
               output pid, output hit, input ready);
  modport dst (input valid, input paddr, input vaddr, input len, input last,
               input pid, input hit, output ready);

endinterface

`default_nettype wire

//--- src/tlb_parser.sv
/*
 * Splits a host request into chunks of at most PMTU_BYTES.
 * Zero-length requests are not supported. One request is in flight at a time,
 * each chunk costs a parse cycle plus a send cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_parser (
  input  logic                  aclk,
  input  logic                  aresetn,

  input  logic                  req_valid,
  output logic                  req_ready,
  input  tlb_types_pkg::vaddr_t req_vaddr,
  input  tlb_types_pkg::len_t   req_len,
  input  logic                  req_ctl,
  input  tlb_types_pkg::pid_t   req_pid,

  chunk_if.src                  chunk
);

  import tlb_cfg_pkg::*;
  import tlb_types_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_PARSE, ST_SEND} state_t;
  state_t state_c, state_n;

  // Remaining part of the latched request
  len_t   len_c, len_n;
  vaddr_t vaddr_c, vaddr_n;
  logic   ctl_c, ctl_n;
  pid_t   pid_c, pid_n;

  // Chunk being offered
  len_t   plen_c, plen_n;
  vaddr_t pvaddr_c, pvaddr_n;
  logic   plast_c, plast_n;

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_c <= ST_IDLE;
    end else begin
      state_c <= state_n;
    end
  end

  // Payload only
  always_ff @(posedge aclk) begin
    len_c    <= len_n;
    vaddr_c  <= vaddr_n;
    ctl_c    <= ctl_n;
    pid_c    <= pid_n;
    plen_c   <= plen_n;
    pvaddr_c <= pvaddr_n;
    plast_c  <= plast_n;
  end

  ////////////////////
  // Next state and datapath
  ////////////////////
  always_comb begin
    state_n  = state_c;
    len_n    = len_c;
    vaddr_n  = vaddr_c;
    ctl_n    = ctl_c;
    pid_n    = pid_c;
    plen_n   = plen_c;
    pvaddr_n = pvaddr_c;
    plast_n  = plast_c;

    req_ready   = 1'b0;
    chunk.valid = 1'b0;

    case (state_c)
      ST_IDLE: begin
        req_ready = 1'b1;
        if (req_valid) begin
          len_n   = req_len;
          vaddr_n = req_vaddr;
          ctl_n   = req_ctl;
          pid_n   = req_pid;
          state_n = ST_PARSE;
        end
      end

      ST_PARSE: begin
        pvaddr_n = vaddr_c;
        // Full PMTU chunk, more to follow
        if (len_c > len_t'(PMTU_BYTES)) begin
          vaddr_n = vaddr_c + vaddr_t'(PMTU_BYTES);
          len_n   = len_c - len_t'(PMTU_BYTES);
          plen_n  = len_t'(PMTU_BYTES);
          plast_n = 1'b0;
        end else begin
          // Tail chunk carries the request's ctl
          len_n   = '0;
          plen_n  = len_c;
          plast_n = ctl_c;
        end
        state_n = ST_SEND;
      end

      ST_SEND: begin
        chunk.valid = 1'b1;
        if (chunk.ready) begin
          state_n = (len_c != '0) ? ST_PARSE : ST_IDLE;
        end
      end

      default: state_n = ST_IDLE;
    endcase
  end

  // Offered chunk fields
  assign chunk.vaddr = pvaddr_c;
  assign chunk.len   = plen_c;
  assign chunk.last  = plast_c;
  assign chunk.pid   = pid_c;

endmodule

`default_nettype wire

//--- src/tlb_lookup.sv
/*
 * Fully associative TLB with a host write port and one registered stage.
 * A chunk is translated by its start address only, so page crossings are not seen.
 * A write lands on the next edge, a lookup in the same cycle sees the old entry.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup (
  input  logic                    aclk,
  input  logic                    aresetn,

  input  logic                    cfg_wr,
  input  tlb_types_pkg::tlb_idx_t cfg_idx,
  input  logic                    cfg_vld,
  input  tlb_types_pkg::vpn_t     cfg_vpn,
  input  tlb_types_pkg::ppn_t     cfg_ppn,
  input  tlb_types_pkg::pid_t     cfg_pid,

  chunk_if.dst                    chunk,
  xlat_if.src                     xlat
);

  import tlb_cfg_pkg::*;
  import tlb_types_pkg::*;

  // Entry storage
  logic ent_vld [TLB_ENTRIES];
  vpn_t ent_vpn [TLB_ENTRIES];
  ppn_t ent_ppn [TLB_ENTRIES];
  pid_t ent_pid [TLB_ENTRIES];

  vpn_t     chunk_vpn;
  logic     match;
  tlb_idx_t match_idx;
  paddr_t   match_paddr;
  logic     accept;

  ////////////////////
  // Host write port
  ////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        ent_vld[i] <= 1'b0;
      end
    end else if (cfg_wr) begin
      ent_vld[cfg_idx] <= cfg_vld;
    end
  end

  always_ff @(posedge aclk) begin
    if (cfg_wr) begin
      ent_vpn[cfg_idx] <= cfg_vpn;
      ent_ppn[cfg_idx] <= cfg_ppn;
      ent_pid[cfg_idx] <= cfg_pid;
    end
  end

  ////////////////////
  // Match
  ////////////////////
  assign chunk_vpn = chunk.vaddr[VADDR_BITS-1:PAGE_BITS];

  // Scan downwards so the lowest matching index is kept
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (ent_vld[i] && ent_vpn[i] == chunk_vpn && ent_pid[i] == chunk.pid) begin
        match     = 1'b1;
        match_idx = tlb_idx_t'(i);
      end
    end
  end

  // Page frame plus offset, zero on a miss
  assign match_paddr = match ? {ent_ppn[match_idx], chunk.vaddr[PAGE_BITS-1:0]} : '0;

  ////////////////////
  // Output register
  ////////////////////
  // Take a chunk when empty or when the held one leaves this cycle
  assign chunk.ready = !xlat.valid || xlat.ready;
  assign accept      = chunk.valid && chunk.ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      xlat.valid <= 1'b0;
    end else if (accept) begin
      xlat.valid <= 1'b1;
    end else if (xlat.ready) begin
      xlat.valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      xlat.paddr <= match_paddr;
      xlat.vaddr <= chunk.vaddr;
      xlat.len   <= chunk.len;
      xlat.last  <= chunk.last;
      xlat.pid   <= chunk.pid;
      xlat.hit   <= match;
    end
  end

endmodule

`default_nettype wire

//--- src/tlb_result.sv
/*
 * Result stage. Hits go to the out register, misses raise a one-cycle pulse.
 * The miss port has no back-pressure, a missed chunk is dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_result (
  input  logic                  aclk,
  input  logic                  aresetn,

  xlat_if.dst                   xlat,

  output logic                  out_valid,
  input  logic                  out_ready,
  output tlb_types_pkg::paddr_t out_paddr,
  output tlb_types_pkg::len_t   out_len,
  output logic                  out_last,
  output tlb_types_pkg::pid_t   out_pid,

  output logic                  miss_valid,
  output tlb_types_pkg::vaddr_t miss_vaddr,
  output tlb_types_pkg::pid_t   miss_pid
);

  logic accept;
  logic take_hit;
  logic take_miss;

  // Same rule as lookup, empty or draining
  assign xlat.ready = !out_valid || out_ready;
  assign accept     = xlat.valid && xlat.ready;
  assign take_hit   = accept && xlat.hit;
  assign take_miss  = accept && !xlat.hit;

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
    end else if (take_hit) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take_hit) begin
      out_paddr <= xlat.paddr;
      out_len   <= xlat.len;
      out_last  <= xlat.last;
      out_pid   <= xlat.pid;
    end
  end

  ////////////////////
  // Miss pulse
  ////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      miss_valid <= 1'b0;
    end else begin
      miss_valid <= take_miss;
    end
  end

  // Fields stay from the last miss
  always_ff @(posedge aclk) begin
    if (take_miss) begin
      miss_vaddr <= xlat.vaddr;
      miss_pid   <= xlat.pid;
    end
  end

endmodule

`default_nettype wire

//--- src/tlb_req_top.sv
/*
 * Request path top level, parser then lookup then result.
 * First out_valid comes four cycles after a request is accepted.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_req_top (
  input  logic                    aclk,
  input  logic                    aresetn,

  // Host requests
  input  logic                    req_valid,
  output logic                    req_ready,
  input  tlb_types_pkg::vaddr_t   req_vaddr,
  input  tlb_types_pkg::len_t     req_len,
  input  logic                    req_ctl,
  input  tlb_types_pkg::pid_t     req_pid,

  // TLB write port
  input  logic                    cfg_wr,
  input  tlb_types_pkg::tlb_idx_t cfg_idx,
  input  logic                    cfg_vld,
  input  tlb_types_pkg::vpn_t     cfg_vpn,
  input  tlb_types_pkg::ppn_t     cfg_ppn,
  input  tlb_types_pkg::pid_t     cfg_pid,

  // Translated chunks
  output logic                    out_valid,
  input  logic                    out_ready,
  output tlb_types_pkg::paddr_t   out_paddr,
  output tlb_types_pkg::len_t     out_len,
  output logic                    out_last,
  output tlb_types_pkg::pid_t     out_pid,

  // Miss pulses
  output logic                    miss_valid,
  output tlb_types_pkg::vaddr_t   miss_vaddr,
  output tlb_types_pkg::pid_t     miss_pid
);

  chunk_if chunk_bus ();
  xlat_if  xlat_bus ();

  ////////////////////
  // Stages
  ////////////////////
  tlb_parser u_parser (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_vaddr (req_vaddr),
    .req_len   (req_len),
    .req_ctl   (req_ctl),
    .req_pid   (req_pid),
    .chunk     (chunk_bus)
  );

  tlb_lookup u_lookup (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cfg_wr  (cfg_wr),
    .cfg_idx (cfg_idx),
    .cfg_vld (cfg_vld),
    .cfg_vpn (cfg_vpn),
    .cfg_ppn (cfg_ppn),
    .cfg_pid (cfg_pid),
    .chunk   (chunk_bus),
    .xlat    (xlat_bus)
  );

  tlb_result u_result (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .xlat       (xlat_bus),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_paddr  (out_paddr),
    .out_len    (out_len),
    .out_last   (out_last),
    .out_pid    (out_pid),
    .miss_valid (miss_valid),
    .miss_vaddr (miss_vaddr),
    .miss_pid   (miss_pid)
  );

endmodule

`default_nettype wire

//--- test/tlb_req_props.sv
/*
 * Protocol properties on the top-level ports of the request path, bound into
 * tlb_req_top. Out stability checks are off while aresetn is low.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_req_props (
  input logic                  aclk,
  input logic                  aresetn,
  input logic                  req_ready,
  input logic                  out_valid,
  input logic                  out_ready,
  input tlb_types_pkg::paddr_t out_paddr,
  input tlb_types_pkg::len_t   out_len,
  input logic                  out_last,
  input tlb_types_pkg::pid_t   out_pid,
  input logic                  miss_valid
);

  ////////////////////
  // Out handshake
  ////////////////////
  // Stalled chunk keeps its fields
  out_stable_a: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> $stable({out_paddr, out_len, out_last, out_pid}))
    else $error("out data changed while out_valid was held");

  out_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped before its transfer");

  ////////////////////
  // Reset
  ////////////////////
  // First cycle after release
  reset_exit_a: assert property (@(posedge aclk)
    $rose(aresetn) |-> !out_valid && !miss_valid && req_ready)
    else $error("outputs not in reset state when reset was released");

  reset_quiet_a: assert property (@(posedge aclk)
    !aresetn |-> !$rose(out_valid) && !$rose(miss_valid))
    else $error("out_valid or miss_valid rose during reset");

endmodule

bind tlb_req_top tlb_req_props props (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .req_ready  (req_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_paddr  (out_paddr),
  .out_len    (out_len),
  .out_last   (out_last),
  .out_pid    (out_pid),
  .miss_valid (miss_valid)
);

`default_nettype wire

//--- test/tlb_req_tb.sv
/*
 * Testbench of the TLB request path. A model TLB and queues of expected chunks
 * and misses feed the assertions on every out transfer and miss pulse.
 * Requests never have zero length. Only entries 0 to 3 are hit by random traffic.
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_req_tb;

  import tlb_cfg_pkg::*;
  import tlb_types_pkg::*;

  localparam int NUM_DIRECTED = 9;
  localparam int NUM_RAND = 40;
  localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RAND) * 40 + 200;
  // Packed expected words {paddr, len, last, pid} and {vaddr, pid}
  localparam int OUT_W = PADDR_BITS + LEN_BITS + 1 + PID_BITS;
  localparam int MISS_W = VADDR_BITS + PID_BITS;

  logic     aclk;
  logic     aresetn;
  logic     req_valid;
  logic     req_ready;
  vaddr_t   req_vaddr;
  len_t     req_len;
  logic     req_ctl;
  pid_t     req_pid;
  logic     cfg_wr;
  tlb_idx_t cfg_idx;
  logic     cfg_vld;
  vpn_t     cfg_vpn;
  ppn_t     cfg_ppn;
  pid_t     cfg_pid;
  logic     out_valid;
  logic     out_ready = 1'b1;
  paddr_t   out_paddr;
  len_t     out_len;
  logic     out_last;
  pid_t     out_pid;
  logic     miss_valid;
  vaddr_t   miss_vaddr;
  pid_t     miss_pid;

  // Model copy of the programmed TLB
  logic m_vld [TLB_ENTRIES];
  vpn_t m_vpn [TLB_ENTRIES];
  ppn_t m_ppn [TLB_ENTRIES];
  pid_t m_pid [TLB_ENTRIES];

  // Expected traffic consumed through read pointers
  logic [OUT_W-1:0]  out_q [$];
  logic [MISS_W-1:0] miss_q [$];
  int                out_rd = 0;
  int                miss_rd = 0;
  logic [OUT_W-1:0]  out_head = '0;
  logic [MISS_W-1:0] miss_head = '0;
  logic              out_pend = 1'b0;
  logic              miss_pend = 1'b0;

  string        test_name = "reset";
  integer       seed;
  logic [31:0]  rnd;
  tlb_idx_t     pick;
  logic         bp_on = 1'b0;
  logic [255:0] stall_pat = '1;
  logic [7:0]   stall_ptr = '0;

  tlb_req_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // Random stalls on the out port while back-pressure is on
  always @(negedge aclk) begin
    out_ready = bp_on ? stall_pat[stall_ptr] : 1'b1;
    stall_ptr = stall_ptr + 8'd1;
  end

  ////////////////////
  // Queue heads
  ////////////////////
  always @(posedge aclk) begin
    if (out_valid && out_ready && out_rd < out_q.size()) begin
      out_rd = out_rd + 1;
    end
    if (miss_valid && miss_rd < miss_q.size()) begin
      miss_rd = miss_rd + 1;
    end
    // Heads move with the DUT outputs after this edge
    out_pend  <= (out_rd < out_q.size());
    miss_pend <= (miss_rd < miss_q.size());
    if (out_rd < out_q.size()) begin
      out_head <= out_q[out_rd];
    end
    if (miss_rd < miss_q.size()) begin
      miss_head <= miss_q[miss_rd];
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at first error");
  endtask

  function automatic string out_text(input logic [OUT_W-1:0] w);
    return $sformatf("paddr=%h len=%0d last=%b pid=%0d", w[OUT_W-1 -: PADDR_BITS],
                     w[PID_BITS+LEN_BITS:PID_BITS+1], w[PID_BITS], w[PID_BITS-1:0]);
  endfunction

  function automatic string miss_text(input logic [MISS_W-1:0] w);
    return $sformatf("vaddr=%h pid=%0d", w[MISS_W-1:PID_BITS], w[PID_BITS-1:0]);
  endfunction

  ////////////////////
  // Checks
  ////////////////////
  out_expected_a: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && out_ready |-> out_pend)
    else stop_with_error($sformatf("Out transfer with no chunk expected in test %s", test_name));

  out_data_a: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && out_ready && out_pend |-> {out_paddr, out_len, out_last, out_pid} == out_head)
    else stop_with_error($sformatf("** Error %s: out expected %s, actual %s", test_name,
      out_text($sampled(out_head)),
      out_text($sampled({out_paddr, out_len, out_last, out_pid}))));

  miss_expected_a: assert property (@(posedge aclk) disable iff (!aresetn)
    miss_valid |-> miss_pend)
    else stop_with_error($sformatf("Miss pulse with no miss expected in test %s", test_name));

  miss_data_a: assert property (@(posedge aclk) disable iff (!aresetn)
    miss_valid && miss_pend |-> {miss_vaddr, miss_pid} == miss_head)
    else stop_with_error($sformatf("** Error %s: miss expected %s, actual %s", test_name,
      miss_text($sampled(miss_head)), miss_text($sampled({miss_vaddr, miss_pid}))));

  ////////////////////
  // Model and drivers
  ////////////////////
  // Lowest matching index wins
  function automatic int find_entry(input vpn_t vpn, input pid_t pid);
    int found;
    found = -1;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (found < 0 && m_vld[i] && m_vpn[i] == vpn && m_pid[i] == pid) begin
        found = i;
      end
    end
    return found;
  endfunction

  task automatic drain_wait();
    while (out_rd != out_q.size() || miss_rd != miss_q.size()) begin
      @(negedge aclk);
    end
  endtask

  task automatic write_entry(input tlb_idx_t idx, input logic vld, input vpn_t vpn,
                             input ppn_t ppn, input pid_t pid);
    // No lookup in flight while the table changes
    drain_wait();
    @(negedge aclk);
    cfg_wr  = 1'b1;
    cfg_idx = idx;
    cfg_vld = vld;
    cfg_vpn = vpn;
    cfg_ppn = ppn;
    cfg_pid = pid;
    @(negedge aclk);
    cfg_wr = 1'b0;
    m_vld[idx] = vld;
    m_vpn[idx] = vpn;
    m_ppn[idx] = ppn;
    m_pid[idx] = pid;
  endtask

  task automatic send_req(input vaddr_t vaddr, input len_t len, input logic ctl,
                          input pid_t pid);
    vaddr_t addr;
    len_t   left;
    len_t   clen;
    logic   clast;
    int     hit_idx;
    addr = vaddr;
    left = len;
    // Expected chunks of at most PMTU_BYTES looked up by their start
    while (left != '0) begin
      clen    = (left > len_t'(PMTU_BYTES)) ? len_t'(PMTU_BYTES) : left;
      clast   = (left > len_t'(PMTU_BYTES)) ? 1'b0 : ctl;
      hit_idx = find_entry(addr[VADDR_BITS-1:PAGE_BITS], pid);
      if (hit_idx >= 0) begin
        out_q.push_back({m_ppn[hit_idx], addr[PAGE_BITS-1:0], clen, clast, pid});
      end else begin
        miss_q.push_back({addr, pid});
      end
      addr = addr + vaddr_t'(clen);
      left = left - clen;
    end
    @(negedge aclk);
    req_valid = 1'b1;
    req_vaddr = vaddr;
    req_len   = len;
    req_ctl   = ctl;
    req_pid   = pid;
    while (!req_ready) begin
      @(negedge aclk);
    end
    @(negedge aclk);
    req_valid = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    stop_with_error($sformatf("Timeout after %0d cycles in test %s", WATCHDOG_CYCLES,
                              test_name));
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    seed      = 32'h7ff6_64a0;
    aresetn   = 1'b0;
    req_valid = 1'b0;
    req_vaddr = '0;
    req_len   = '0;
    req_ctl   = 1'b0;
    req_pid   = '0;
    cfg_wr    = 1'b0;
    cfg_idx   = '0;
    cfg_vld   = 1'b0;
    cfg_vpn   = '0;
    cfg_ppn   = '0;
    cfg_pid   = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      m_vld[i] = 1'b0;
    end
    for (int k = 0; k < 8; k++) begin
      stall_pat[32*k +: 32] = $random(seed);
    end
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    test_name = "single_chunk";
    write_entry(3'd0, 1'b1, 20'h00010, 20'h80000, 6'd1);
    write_entry(3'd1, 1'b1, 20'h00011, 20'h80123, 6'd1);
    write_entry(3'd2, 1'b1, 20'h00200, 20'h9abcd, 6'd7);
    write_entry(3'd3, 1'b1, 20'h00300, 20'h12345, 6'd2);
    // Shadowed by entry 1
    write_entry(3'd4, 1'b1, 20'h00011, 20'hfffff, 6'd1);
    send_req(32'h0001_0010, 16'd64, 1'b1, 6'd1);
    send_req(32'h0001_1f00, 16'd256, 1'b0, 6'd1);
    send_req(32'h0020_0abc, 16'd1, 1'b1, 6'd7);

    drain_wait();
    test_name = "splitting";
    send_req(32'h0001_0100, 16'd1000, 1'b1, 6'd1);
    send_req(32'h0020_0000, 16'd768, 1'b1, 6'd7);
    // Second chunk lands in the next page
    send_req(32'h0001_0f00, 16'd513, 1'b0, 6'd1);

    drain_wait();
    test_name = "misses";
    send_req(32'h0055_5000, 16'd300, 1'b1, 6'd1);
    send_req(32'h0001_0000, 16'd100, 1'b0, 6'd3);
    write_entry(3'd3, 1'b0, 20'h00300, 20'h12345, 6'd2);
    send_req(32'h0030_0040, 16'd600, 1'b1, 6'd2);

    drain_wait();
    test_name = "back_pressure";
    write_entry(3'd3, 1'b1, 20'h00300, 20'h12345, 6'd2);
    bp_on <= 1'b1;
    for (int n = 0; n < NUM_RAND; n++) begin
      rnd  = $random(seed);
      pick = {1'b0, rnd[1:0]};
      // About one in four with a foreign pid
      send_req({m_vpn[pick], rnd[11:0]}, len_t'(rnd[21:12]) + len_t'(1), rnd[22],
               (rnd[24:23] == 2'b00) ? pid_t'(rnd[30:25]) : m_pid[pick]);
    end
    drain_wait();
    bp_on <= 1'b0;
    repeat (20) @(negedge aclk);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/tlb_cfg_pkg.sv
src/tlb_types_pkg.sv
src/tlb_intf.sv
src/tlb_parser.sv
src/tlb_lookup.sv
src/tlb_result.sv
src/tlb_req_top.sv
test/tlb_req_props.sv
test/tlb_req_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the TLB request path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tlb_req_tb -o tlb_req_sim

# The simulator status is not used, the log decides
./obj_dir/tlb_req_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
